// ==== invaders_cfg.svh ====
`ifndef INVADERS_CFG_SVH
`define INVADERS_CFG_SVH

//////////////////////////////////////////////////
// Playfield limits
//////////////////////////////////////////////////

// Side edges the alien boxes must stay inside
`define FIELD_LEFT   11'd5
`define FIELD_RIGHT  11'd635
// Laser centre row where alien shots end
`define FIELD_FLOOR  11'd445
// Alien centre row that counts as a landing
`define LAND_Y       11'd384

//////////////////////////////////////////////////
// Object sizes and motion
//////////////////////////////////////////////////

// Half sizes, box spans centre +/- half
`define ALIEN_HALF_W 11'd15
`define ALIEN_HALF_H 11'd8
`define LASER_HALF_W 11'd1
`define LASER_HALF_H 11'd5
// March step in pixels
`define STEP_X       11'd10
`define STEP_Y       11'd10
// Alien laser drop per frame
`define LASER_SPEED  11'd4
// Frames between march steps
`define STEP_FRAMES  12'd4

// Fleet size and home layout, one row
`define FLEET_COUNT  3
`define FLEET_X0     11'd100
`define FLEET_Y0     11'd60
`define FLEET_PITCH  11'd60

// Colours, packed blue/green/red
`define COLOR_ALIEN  8'hAA
`define COLOR_LASER  8'hFF
`define COLOR_BLANK  8'h00

`endif

// ==== screen_pkg.sv ====
`default_nettype none

package screen_pkg;

	//////////////////////////////////////////////////
	// Raster types
	//////////////////////////////////////////////////

	// Screen coordinate, wide enough for any x or y
	typedef logic [10:0] coord_t;

	// Colour byte
	// [7:6] blue, [5:3] green, [2:0] red
	typedef logic [7:0] color_t;

	// Game mode from the top-level game FSM
	// Title and ready hold objects at home
	// Play runs the frame updates
	// Over freezes the whole scene
	typedef enum logic [1:0] {
		MODE_TITLE = 2'd0,
		MODE_READY = 2'd1,
		MODE_PLAY  = 2'd2,
		MODE_OVER  = 2'd3
	} game_mode_t;

endpackage

`default_nettype wire

// ==== fleet_pkg.sv ====
`default_nettype none

package fleet_pkg;

	//////////////////////////////////////////////////
	// Fleet movement types
	//////////////////////////////////////////////////

	// Lateral direction of the whole fleet
	typedef enum logic {
		MARCH_RIGHT = 1'b0,
		MARCH_LEFT  = 1'b1
	} march_dir_t;

	// Step command sent to every alien
	// Down is issued instead of a lateral step at an edge
	typedef enum logic [1:0] {
		STEP_RIGHT = 2'd0,
		STEP_LEFT  = 2'd1,
		STEP_DOWN  = 2'd2
	} step_kind_t;

	// Frame counter for shot period and step rate
	typedef logic [11:0] frame_cnt_t;

endpackage

`default_nettype wire

// ==== alien_ship.sv ====
`include "invaders_cfg.svh"
`default_nettype none

module alien_ship
	import screen_pkg::*, fleet_pkg::*;
#(
	parameter coord_t home_x = `FLEET_X0,
	parameter coord_t home_y = `FLEET_Y0
) (
	input  wire         clk,
	input  wire         reset,
	input  game_mode_t  mode,
	input  coord_t      pixel_x,
	input  coord_t      pixel_y,
	input  coord_t      ship_laser_x,
	input  coord_t      ship_laser_y,
	input  frame_cnt_t  shoot_period,
	input  wire         barrier_hit,
	input  wire         step,
	input  step_kind_t  step_kind,
	input  march_dir_t  march_dir,
	output logic        alive,
	output logic        at_edge,
	output logic        landed,
	output logic        alien_px,
	output logic        laser_px
);

	// Alien centre
	coord_t pos_x;
	coord_t pos_y;
	// Laser centre and flight flag
	coord_t laser_x;
	coord_t laser_y;
	logic laser_active;
	// Frames since last shot
	frame_cnt_t shot_cnt;

	logic frame_tick;
	logic hold_home;
	logic hit;

	// One cycle per frame, only while playing
	assign frame_tick = (pixel_x == '0) && (pixel_y == '0) && (mode == MODE_PLAY);
	// Title and ready park the alien at home
	assign hold_home = reset || (mode == MODE_TITLE) || (mode == MODE_READY);

	// Player laser point inside alien box
	// Lower bounds written as a + half >= b to avoid wrap below zero
	assign hit = (ship_laser_x + `ALIEN_HALF_W >= pos_x)
		&& (ship_laser_x <= pos_x + `ALIEN_HALF_W)
		&& (ship_laser_y + `ALIEN_HALF_H >= pos_y)
		&& (ship_laser_y <= pos_y + `ALIEN_HALF_H);

	//////////////////////////////////////////////////
	// Edge and landing flags
	//////////////////////////////////////////////////

	always_comb begin
		at_edge = 1'b0;
		if (alive) begin
			// Would the next lateral step push the box past the field
			if (march_dir == MARCH_RIGHT)
				at_edge = (pos_x + `ALIEN_HALF_W + `STEP_X > `FIELD_RIGHT);
			else
				at_edge = (pos_x < `FIELD_LEFT + `ALIEN_HALF_W + `STEP_X);
		end
	end

	assign landed = alive && (pos_y >= `LAND_Y);

	//////////////////////////////////////////////////
	// Position, life and laser
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (hold_home) begin
			pos_x <= home_x;
			pos_y <= home_y;
			alive <= 1'b1;
			laser_x <= home_x;
			laser_y <= home_y;
			laser_active <= 1'b0;
			shot_cnt <= '0;
		end else begin
			// March step from the fleet controller
			if (step && alive) begin
				case (step_kind)
					STEP_RIGHT: pos_x <= pos_x + `STEP_X;
					STEP_LEFT:  pos_x <= pos_x - `STEP_X;
					STEP_DOWN:  pos_y <= pos_y + `STEP_Y;
					default:    pos_x <= pos_x;
				endcase
			end
			if (frame_tick && alive) begin
				if (hit) begin
					// Killed, its laser goes with it
					alive <= 1'b0;
					laser_active <= 1'b0;
				end else if (laser_active) begin
					// Drop until the floor is reached
					if (laser_y >= `FIELD_FLOOR)
						laser_active <= 1'b0;
					else
						laser_y <= laser_y + `LASER_SPEED;
				end else if (shot_cnt >= shoot_period) begin
					// Fire from the alien centre
					shot_cnt <= '0;
					laser_active <= 1'b1;
					laser_x <= pos_x;
					laser_y <= pos_y;
				end else begin
					shot_cnt <= shot_cnt + 12'd1;
				end
			end
			// Shot stopped by a barrier, any cycle of play
			if (barrier_hit && (mode == MODE_PLAY))
				laser_active <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Render
	//////////////////////////////////////////////////

	assign alien_px = alive
		&& (pixel_x + `ALIEN_HALF_W >= pos_x) && (pixel_x <= pos_x + `ALIEN_HALF_W)
		&& (pixel_y + `ALIEN_HALF_H >= pos_y) && (pixel_y <= pos_y + `ALIEN_HALF_H);

	// Only a laser in flight is drawn
	assign laser_px = laser_active
		&& (pixel_x + `LASER_HALF_W >= laser_x) && (pixel_x <= laser_x + `LASER_HALF_W)
		&& (pixel_y + `LASER_HALF_H >= laser_y) && (pixel_y <= laser_y + `LASER_HALF_H);

endmodule

`default_nettype wire

// ==== fleet_march.sv ====
`include "invaders_cfg.svh"
`default_nettype none

module fleet_march
	import screen_pkg::*, fleet_pkg::*;
(
	input  wire                     clk,
	input  wire                     reset,
	input  game_mode_t              mode,
	input  coord_t                  pixel_x,
	input  coord_t                  pixel_y,
	input  wire [`FLEET_COUNT-1:0]  at_edge,
	input  wire [`FLEET_COUNT-1:0]  landed,
	output logic                    step,
	output step_kind_t              step_kind,
	output march_dir_t              march_dir,
	output logic                    fleet_landed
);

	march_dir_t dir_next;
	frame_cnt_t step_cnt;
	logic frame_tick;
	logic hold_home;
	logic any_edge;

	assign frame_tick = (pixel_x == '0) && (pixel_y == '0) && (mode == MODE_PLAY);
	assign hold_home = reset || (mode == MODE_TITLE) || (mode == MODE_READY);

	// Any live alien touching a side or the landing row
	assign any_edge = |at_edge;
	assign fleet_landed = |landed;

	//////////////////////////////////////////////////
	// Step pulse and kind
	//////////////////////////////////////////////////

	// Last frame of each step period, halted after landing
	assign step = frame_tick && (step_cnt == `STEP_FRAMES - 12'd1) && !fleet_landed;

	// Edge forces a drop, otherwise keep marching
	assign step_kind = any_edge ? STEP_DOWN
		: ((march_dir == MARCH_RIGHT) ? STEP_RIGHT : STEP_LEFT);

	// Direction FSM, flips together with the drop
	always_comb begin
		dir_next = march_dir;
		if (step && any_edge) begin
			case (march_dir)
				MARCH_RIGHT: dir_next = MARCH_LEFT;
				MARCH_LEFT:  dir_next = MARCH_RIGHT;
				default:     dir_next = MARCH_RIGHT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (hold_home) begin
			march_dir <= MARCH_RIGHT;
			step_cnt <= '0;
		end else if (frame_tick) begin
			march_dir <= dir_next;
			// Wrap the frame counter every step period
			if (step_cnt == `STEP_FRAMES - 12'd1)
				step_cnt <= '0;
			else
				step_cnt <= step_cnt + 12'd1;
		end
	end

endmodule

`default_nettype wire

// ==== pixel_mux.sv ====
`include "invaders_cfg.svh"
`default_nettype none

module pixel_mux
	import screen_pkg::*;
(
	input  wire                     clk,
	input  wire                     reset,
	input  wire [`FLEET_COUNT-1:0]  alien_px,
	input  wire [`FLEET_COUNT-1:0]  laser_px,
	output color_t                  pixel_rgb,
	output logic                    pixel_on
);

	color_t rgb_next;
	logic on_next;

	//////////////////////////////////////////////////
	// Priority merge
	//////////////////////////////////////////////////

	// Lasers are drawn over ships
	always_comb begin
		if (|laser_px) begin
			rgb_next = `COLOR_LASER;
			on_next = 1'b1;
		end else if (|alien_px) begin
			rgb_next = `COLOR_ALIEN;
			on_next = 1'b1;
		end else begin
			// Nothing of the fleet here
			rgb_next = `COLOR_BLANK;
			on_next = 1'b0;
		end
	end

	// One stage, colour lands on the next scan cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			pixel_rgb <= `COLOR_BLANK;
			pixel_on <= 1'b0;
		end else begin
			pixel_rgb <= rgb_next;
			pixel_on <= on_next;
		end
	end

endmodule

`default_nettype wire

// ==== alien_fleet.sv ====
`include "invaders_cfg.svh"
`default_nettype none

module alien_fleet
	import screen_pkg::*, fleet_pkg::*;
(
	input  wire                     clk,
	input  wire                     reset,
	input  game_mode_t              mode,
	input  coord_t                  pixel_x,
	input  coord_t                  pixel_y,
	input  coord_t                  ship_laser_x,
	input  coord_t                  ship_laser_y,
	input  frame_cnt_t              shoot_period,
	input  wire [`FLEET_COUNT-1:0]  barrier_hit,
	output color_t                  pixel_rgb,
	output logic                    pixel_on,
	output logic [`FLEET_COUNT-1:0] alive,
	output logic                    fleet_landed
);

	// March commands, shared by all aliens
	logic step;
	step_kind_t step_kind;
	march_dir_t march_dir;

	// Per-alien flags and pixel hits
	logic [`FLEET_COUNT-1:0] at_edge;
	logic [`FLEET_COUNT-1:0] landed;
	logic [`FLEET_COUNT-1:0] alien_px;
	logic [`FLEET_COUNT-1:0] laser_px;

	//////////////////////////////////////////////////
	// Alien row
	//////////////////////////////////////////////////

	for (genvar i = 0; i < `FLEET_COUNT; i++) begin : g_alien
		// Evenly spaced along one row
		alien_ship #(
			.home_x (coord_t'(`FLEET_X0 + i * `FLEET_PITCH)),
			.home_y (`FLEET_Y0)
		) u_alien_ship (
			.clk          (clk),
			.reset        (reset),
			.mode         (mode),
			.pixel_x      (pixel_x),
			.pixel_y      (pixel_y),
			.ship_laser_x (ship_laser_x),
			.ship_laser_y (ship_laser_y),
			.shoot_period (shoot_period),
			.barrier_hit  (barrier_hit[i]),
			.step         (step),
			.step_kind    (step_kind),
			.march_dir    (march_dir),
			.alive        (alive[i]),
			.at_edge      (at_edge[i]),
			.landed       (landed[i]),
			.alien_px     (alien_px[i]),
			.laser_px     (laser_px[i])
		);
	end

	// March controller
	fleet_march u_fleet_march (
		.clk          (clk),
		.reset        (reset),
		.mode         (mode),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.at_edge      (at_edge),
		.landed       (landed),
		.step         (step),
		.step_kind    (step_kind),
		.march_dir    (march_dir),
		.fleet_landed (fleet_landed)
	);

	// Registered colour output
	pixel_mux u_pixel_mux (
		.clk       (clk),
		.reset     (reset),
		.alien_px  (alien_px),
		.laser_px  (laser_px),
		.pixel_rgb (pixel_rgb),
		.pixel_on  (pixel_on)
	);

endmodule

`default_nettype wire

// ==== tb_alien_fleet.sv ====
`include "invaders_cfg.svh"
`default_nettype none

module tb_alien_fleet
	import screen_pkg::*, fleet_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N = `FLEET_COUNT;
	localparam int X0 = `FLEET_X0;
	localparam int Y0 = `FLEET_Y0;
	localparam int PITCH = `FLEET_PITCH;
	localparam int AHW = `ALIEN_HALF_W;
	localparam int AHH = `ALIEN_HALF_H;
	localparam int LHH = `LASER_HALF_H;
	localparam int SX = `STEP_X;
	localparam int SY = `STEP_Y;
	localparam int SF = `STEP_FRAMES;
	localparam int LSP = `LASER_SPEED;
	localparam logic [N-1:0] ALL = '1;

	logic clk = 1'b0;
	logic reset = 1'b1;
	game_mode_t mode = MODE_TITLE;
	// Scan parks off screen between probes
	coord_t pixel_x = 11'd700;
	coord_t pixel_y = 11'd500;
	// Player laser far from every alien
	coord_t ship_laser_x = 11'd1000;
	coord_t ship_laser_y = 11'd1000;
	frame_cnt_t shoot_period = 12'hFFF;
	logic [N-1:0] barrier_hit = '0;
	color_t pixel_rgb;
	logic pixel_on;
	logic [N-1:0] alive;
	logic fleet_landed;

	// Fleet model with one shared row
	int mx[N];
	int my;
	logic [N-1:0] malive;
	bit mleft;
	int mcnt;
	int msteps;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed = 0;
	bit [31:0] rng = 32'd57;

	alien_fleet u_alien_fleet (
		.clk          (clk),
		.reset        (reset),
		.mode         (mode),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.ship_laser_x (ship_laser_x),
		.ship_laser_y (ship_laser_y),
		.shoot_period (shoot_period),
		.barrier_hit  (barrier_hit),
		.pixel_rgb    (pixel_rgb),
		.pixel_on     (pixel_on),
		.alive        (alive),
		.fleet_landed (fleet_landed)
	);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////
	// Model of the march rules
	//////////////////////////////////////////////////

	function automatic bit [31:0] xorshift(input bit [31:0] s);
		bit [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Next lateral step would leave the field
	// Signed compare, the left test goes below zero
	function automatic bit model_edge();
		bit e;
		e = 1'b0;
		for (int i = 0; i < N; i++) begin
			if (malive[i] && mleft)
				e |= (mx[i] - AHW - SX < int'(`FIELD_LEFT));
			else if (malive[i])
				e |= (mx[i] + AHW + SX > int'(`FIELD_RIGHT));
		end
		return e;
	endfunction

	function automatic bit model_landed();
		return (|malive) && (my >= int'(`LAND_Y));
	endfunction

	// Point inside any live alien box
	function automatic bit covered(input int px, input int py);
		bit c;
		c = 1'b0;
		for (int i = 0; i < N; i++)
			if (malive[i] && px >= mx[i] - AHW && px <= mx[i] + AHW
				&& py >= my - AHH && py <= my + AHH)
				c = 1'b1;
		return c;
	endfunction

	task automatic home_model();
		for (int i = 0; i < N; i++)
			mx[i] = X0 + i * PITCH;
		my = Y0;
		malive = ALL;
		mleft = 1'b0;
		mcnt = 0;
		msteps = 0;
	endtask

	//////////////////////////////////////////////////
	// Drive and check helpers
	//////////////////////////////////////////////////

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Timeout: %s", what);
	endtask

	// Ready for one cycle sends everything home
	task automatic set_mode(input game_mode_t m);
		mode = MODE_READY;
		@(posedge clk);
		#1;
		mode = m;
		home_model();
	endtask

	// One frame tick cycle and then one cycle off (0,0)
	task automatic frame_tick();
		bit edge_hit;
		bit land;
		bit [N-1:0] kill;
		edge_hit = model_edge();
		land = model_landed();
		for (int i = 0; i < N; i++)
			kill[i] = malive[i] && ship_laser_x + AHW >= mx[i] && ship_laser_x <= mx[i] + AHW
				&& ship_laser_y + AHH >= my && ship_laser_y <= my + AHH;
		pixel_x = '0;
		pixel_y = '0;
		@(posedge clk);
		#1;
		pixel_x = 11'd700;
		pixel_y = 11'd500;
		@(posedge clk);
		#1;
		if (mcnt == SF - 1) begin
			mcnt = 0;
			// Drop and reverse at an edge or else step sideways
			if (!land) begin
				msteps++;
				if (edge_hit) begin
					my += SY;
					mleft = !mleft;
				end else begin
					for (int i = 0; i < N; i++)
						if (malive[i])
							mx[i] += mleft ? -SX : SX;
				end
			end
		end else begin
			mcnt++;
		end
		malive &= ~kill;
	endtask

	task automatic wait_step();
		int s;
		int n;
		s = msteps;
		for (n = 0; n < 2 * SF && msteps == s; n++)
			frame_tick();
		if (msteps == s)
			report_failure("no march step within two step periods");
	endtask

	// Colour comes back one cycle after the scan position
	task automatic expect_pixel(input int px, input int py, input color_t rgb, input logic on);
		pixel_x = coord_t'(px);
		pixel_y = coord_t'(py);
		@(posedge clk);
		#1;
		check($sformatf("pixel_rgb at %0d,%0d", px, py), pixel_rgb, rgb);
		check($sformatf("pixel_on at %0d,%0d", px, py), pixel_on, on);
		pixel_x = 11'd700;
		pixel_y = 11'd500;
	endtask

	// Expected colour from the model when no laser is in flight
	task automatic probe_model(input int px, input int py);
		if (covered(px, py))
			expect_pixel(px, py, `COLOR_ALIEN, 1'b1);
		else
			expect_pixel(px, py, `COLOR_BLANK, 1'b0);
	endtask

	// Points in and around a random alien box
	task automatic random_probes(input int count);
		int i;
		int px;
		int py;
		for (int k = 0; k < count; k++) begin
			rng = xorshift(rng);
			i = int'(rng % N);
			px = mx[i] + int'(rng[11:4] % 41) - 20;
			py = my + int'(rng[23:16] % 25) - 12;
			probe_model(px, py);
		end
	endtask

	task automatic clear_lasers();
		barrier_hit = ALL;
		@(posedge clk);
		#1;
		barrier_hit = '0;
	endtask

	task automatic end_test(input string name, input int first_error);
		tests++;
		if (errors == first_error) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("Test %0d %s: %0d errors", tests, name, errors - first_error);
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	initial begin
		int e0;
		int n;
		int oy;
		int ox[N];
		int lx;
		int ly;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		home_model();

		// Home layout in title and again in ready
		e0 = errors;
		check("pixel_on", pixel_on, 0);
		check("pixel_rgb", pixel_rgb, `COLOR_BLANK);
		check("fleet_landed", fleet_landed, 0);
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < N; i++) begin
				expect_pixel(mx[i], my, `COLOR_ALIEN, 1'b1);
				expect_pixel(mx[i] + AHW + 1, my, `COLOR_BLANK, 1'b0);
			end
			check("alive", alive, ALL);
			set_mode(MODE_PLAY);
			repeat (SF) frame_tick();
			set_mode(MODE_READY);
		end
		end_test("reset and idle modes", e0);

		// Four steps right
		e0 = errors;
		set_mode(MODE_PLAY);
		repeat (4 * SF) frame_tick();
		for (int i = 0; i < N; i++) begin
			expect_pixel(X0 + i * PITCH + 4 * SX, Y0, `COLOR_ALIEN, 1'b1);
			probe_model(X0 + i * PITCH, Y0);
		end
		random_probes(8);
		end_test("march", e0);

		// Down at the right edge and then left
		e0 = errors;
		for (n = 0; n < 1000 && !model_edge(); n++)
			frame_tick();
		if (!model_edge())
			report_failure("fleet never reached the right edge");
		for (int i = 0; i < N; i++)
			ox[i] = mx[i];
		oy = my;
		wait_step();
		for (int i = 0; i < N; i++) begin
			expect_pixel(ox[i], oy + SY, `COLOR_ALIEN, 1'b1);
			expect_pixel(ox[i], oy, `COLOR_BLANK, 1'b0);
		end
		wait_step();
		for (int i = 0; i < N; i++) begin
			expect_pixel(ox[i] - SX, oy + SY, `COLOR_ALIEN, 1'b1);
			probe_model(ox[i] + AHW, oy + SY);
		end
		end_test("edge reversal", e0);

		// Counter reaches 2 after two frames and the shot leaves on the third
		e0 = errors;
		set_mode(MODE_PLAY);
		shoot_period = 12'd2;
		repeat (3) frame_tick();
		lx = X0;
		ly = Y0;
		expect_pixel(lx, ly, `COLOR_LASER, 1'b1);
		repeat (5) frame_tick();
		ly += 5 * LSP;
		expect_pixel(lx, ly, `COLOR_LASER, 1'b1);
		expect_pixel(lx, ly + LHH + 1, `COLOR_BLANK, 1'b0);
		expect_pixel(lx, ly - LHH - 1, `COLOR_BLANK, 1'b0);
		frame_tick();
		ly += LSP;
		expect_pixel(lx, ly, `COLOR_LASER, 1'b1);
		expect_pixel(lx, ly - LHH - 1, `COLOR_BLANK, 1'b0);
		// Barrier stops shot 0 only
		barrier_hit = 3'b001;
		@(posedge clk);
		#1;
		barrier_hit = '0;
		expect_pixel(lx, ly, `COLOR_BLANK, 1'b0);
		expect_pixel(lx + PITCH, ly, `COLOR_LASER, 1'b1);
		shoot_period = 12'hFFF;
		end_test("laser life cycle", e0);

		// Player shot on alien 1
		e0 = errors;
		set_mode(MODE_PLAY);
		repeat (2) frame_tick();
		ship_laser_x = coord_t'(mx[1]);
		ship_laser_y = coord_t'(my);
		frame_tick();
		ship_laser_x = 11'd1000;
		ship_laser_y = 11'd1000;
		check("alive", alive, ALL & ~(32'd1 << 1));
		probe_model(mx[1], my);
		repeat (2 * SF) frame_tick();
		check("alive", alive, ALL & ~(32'd1 << 1));
		for (int i = 0; i < N; i++)
			probe_model(mx[i], my);
		random_probes(8);
		end_test("kill", e0);

		// March until the row reaches the landing line
		e0 = errors;
		set_mode(MODE_PLAY);
		for (n = 0; n < 10000 && !model_landed(); n++)
			frame_tick();
		if (!model_landed())
			report_failure("fleet never reached the landing row");
		check("fleet_landed", fleet_landed, 1);
		check("alive", alive, ALL);
		clear_lasers();
		for (int i = 0; i < N; i++)
			ox[i] = mx[i];
		oy = my;
		random_probes(6);
		repeat (3 * SF) frame_tick();
		clear_lasers();
		check("fleet_landed", fleet_landed, 1);
		for (int i = 0; i < N; i++)
			expect_pixel(ox[i], oy, `COLOR_ALIEN, 1'b1);
		end_test("landing", e0);

		$display("Tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
screen_pkg.sv
fleet_pkg.sv
alien_ship.sv
fleet_march.sv
pixel_mux.sv
alien_fleet.sv
tb_alien_fleet.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the fleet testbench with Verilator, run it, judge from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_alien_fleet -f vlog.f \
	&& ./obj_dir/Vtb_alien_fleet | tee sim.log
grep -q '\*\* PASS \*\*' sim.log 2>/dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
